// ==== common/statusPkg.sv ====
package statusPkg;

  typedef enum logic [4:0] {
    ModeUser   = 5'b10000,
    ModeFiq    = 5'b10001,
    ModeIrq    = 5'b10010,
    ModeSvc    = 5'b10011,
    ModeAbort  = 5'b10111,
    ModeUndef  = 5'b11011,
    ModeSystem = 5'b11111
  } mode_t;

  typedef enum logic [2:0] {
    ExcNone,
    ExcDataAbort,
    ExcFiq,
    ExcIrq,
    ExcPrefetchAbort,
    ExcUndef,
    ExcSwi
  } excCode_t;

  typedef struct packed {
    logic [3:0] flags;   // N Z C V
    logic       irqMask; // I, masks irq when set
    logic       fiqMask; // F, masks fiq when set
    logic       thumb;   // T, Thumb state
    mode_t      mode;
  } statusWord_t;

  localparam int          NumBanks = 5;    // svc, abort, undef, irq, fiq
  localparam logic [2:0]  NoBank   = 3'd7; // User and system share no saved word

  localparam logic [1:0]  AdrCpsr    = 2'd0;
  localparam logic [1:0]  AdrSpsr    = 2'd1;
  localparam logic [1:0]  AdrPending = 2'd2;

  localparam statusWord_t ResetStatus = '{flags: 4'b0000, irqMask: 1'b1, fiqMask: 1'b1,
                                          thumb: 1'b0, mode: ModeSvc};

  function automatic logic [31:0] VecOffset(excCode_t code);
    case (code)
      ExcUndef:         return 32'h04;
      ExcSwi:           return 32'h08;
      ExcPrefetchAbort: return 32'h0C;
      ExcDataAbort:     return 32'h10;
      ExcIrq:           return 32'h18;
      ExcFiq:           return 32'h1C;
      default:          return 32'h00; // Reset vector slot
    endcase
  endfunction

  function automatic mode_t EntryMode(excCode_t code);
    case (code)
      ExcDataAbort, ExcPrefetchAbort: return ModeAbort;
      ExcUndef:                       return ModeUndef;
      ExcIrq:                         return ModeIrq;
      ExcFiq:                         return ModeFiq;
      default:                        return ModeSvc; // swi
    endcase
  endfunction

  function automatic logic [2:0] BankIndex(mode_t mode);
    case (mode)
      ModeSvc:   return 3'd0;
      ModeAbort: return 3'd1;
      ModeUndef: return 3'd2;
      ModeIrq:   return 3'd3;
      ModeFiq:   return 3'd4;
      default:   return NoBank;
    endcase
  endfunction

endpackage

// ==== statusReg/statusRegister.sv ====
module statusRegister (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   excTaken,      // Exception entry this cycle
  input  statusPkg::excCode_t    excCode,       // Winning exception
  input  logic                   excReturn,     // Restore saved word of current mode
  input  logic                   flagsWrite,    // Datapath flag update
  input  logic [3:0]             flagsNext,
  input  logic                   thumbNext,
  input  logic                   hostCpsrWrite, // MSR to current word
  input  logic                   hostSpsrWrite, // MSR to saved word
  input  statusPkg::statusWord_t hostData,
  output statusPkg::statusWord_t status,        // Current word
  output statusPkg::statusWord_t spsr           // Saved word of current mode
);

  import statusPkg::*;

  statusWord_t savedWord [NumBanks]; // Banked saved words
  mode_t       entryMode;            // Mode entered on excTaken
  logic [2:0]  entryBank;            // Bank receiving old word
  logic [2:0]  curBank;              // Bank of current mode
  logic        curHasBank;           // Not user or system
  logic        isUser;

  assign entryMode  = EntryMode(excCode);
  assign entryBank  = BankIndex(entryMode);
  assign curBank    = BankIndex(status.mode);
  assign curHasBank = (curBank != NoBank);
  assign isUser     = (status.mode == ModeUser);

  // Saved word of current mode, zero when unbanked
  assign spsr = curHasBank ? savedWord[curBank] : '0;

  // Current word
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      status <= ResetStatus;
    end else if (excTaken) begin
      status.mode    <= entryMode;
      status.irqMask <= 1'b1;               // Every entry masks irq
      if (excCode == ExcFiq) begin
        status.fiqMask <= 1'b1;             // Only fiq masks fiq
      end
      status.thumb   <= 1'b0;               // Handlers run in ARM state
    end else if (excReturn && curHasBank) begin
      status <= savedWord[curBank];         // Return restores saved word
    end else if (hostCpsrWrite) begin
      if (isUser) begin
        status.flags <= hostData.flags;     // User may touch flags only
      end else begin
        status <= hostData;
      end
    end else if (flagsWrite) begin
      status.flags <= flagsNext;
      status.thumb <= thumbNext;
    end
  end

  // Banked saved words
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      for (int b = 0; b < NumBanks; b++) begin
        savedWord[b] <= '0;
      end
    end else if (excTaken) begin
      if (entryBank != NoBank) begin
        savedWord[entryBank] <= status;     // Old word into entry mode bank
      end
    end else if (excReturn && curHasBank) begin
      // Return leaves the banks alone, host write loses this cycle
    end else if (hostCpsrWrite) begin
      // Current word write takes precedence over saved word write
    end else if (hostSpsrWrite && curHasBank) begin
      savedWord[curBank] <= hostData;       // Only current mode's bank
    end
  end

endmodule

// ==== statusReg/exceptionArbiter.sv ====
module exceptionArbiter #(
  parameter logic [31:0] VectorBase = 32'h0000_0000 // Low or high vector table
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   dataAbortReq,     // Pulse
  input  logic                   prefetchAbortReq, // Pulse
  input  logic                   undefReq,         // Pulse
  input  logic                   swiReq,           // Pulse
  input  logic                   irqLine,          // Level
  input  logic                   fiqLine,          // Level
  input  statusPkg::statusWord_t status,           // For I and F masks
  output logic                   excTaken,
  output statusPkg::excCode_t    excCode,
  output logic [31:0]            excVector,
  output logic [3:0]             pending           // dataAbort, prefetchAbort, undef, swi
);

  import statusPkg::*;

  localparam int PendDataAbort     = 3;
  localparam int PendPrefetchAbort = 2;
  localparam int PendUndef         = 1;
  localparam int PendSwi           = 0;

  logic [3:0] reqMask;   // New request pulses
  logic [3:0] clearMask; // Pending bit of the taken exception
  logic       irqActive; // Unmasked irq
  logic       fiqActive; // Unmasked fiq

  assign reqMask   = {dataAbortReq, prefetchAbortReq, undefReq, swiReq};
  assign irqActive = irqLine & ~status.irqMask;
  assign fiqActive = fiqLine & ~status.fiqMask;

  // Fixed priority select
  always_comb begin
    excCode = ExcNone;
    if (pending[PendDataAbort]) begin
      excCode = ExcDataAbort;
    end else if (fiqActive) begin
      excCode = ExcFiq;
    end else if (irqActive) begin
      excCode = ExcIrq;
    end else if (pending[PendPrefetchAbort]) begin
      excCode = ExcPrefetchAbort;
    end else if (pending[PendUndef]) begin
      excCode = ExcUndef;
    end else if (pending[PendSwi]) begin
      excCode = ExcSwi;
    end
  end

  assign excTaken  = (excCode != ExcNone);
  assign excVector = VectorBase + VecOffset(excCode);

  // Only latched sources are cleared, lines drop on their own
  always_comb begin
    clearMask = 4'b0000;
    case (excCode)
      ExcDataAbort:     clearMask[PendDataAbort]     = 1'b1;
      ExcPrefetchAbort: clearMask[PendPrefetchAbort] = 1'b1;
      ExcUndef:         clearMask[PendUndef]         = 1'b1;
      ExcSwi:           clearMask[PendSwi]           = 1'b1;
      default:          clearMask = 4'b0000;
    endcase
  end

  // Pending requests, a new pulse survives a same-cycle clear
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      pending <= 4'b0000;
    end else begin
      pending <= (pending & ~clearMask) | reqMask;
    end
  end

endmodule

// ==== design/statusBusSlave.sv ====
module statusBusSlave (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   wbCyc,
  input  logic                   wbStb,
  input  logic                   wbWe,
  input  logic [1:0]             wbAdr,
  input  logic [31:0]            wbDatW,
  output logic [31:0]            wbDatR,
  output logic                   wbAck,
  input  statusPkg::statusWord_t status,
  input  statusPkg::statusWord_t spsr,
  input  logic [3:0]             pending,
  output logic                   hostCpsrWrite,
  output logic                   hostSpsrWrite,
  output statusPkg::statusWord_t hostData
);

  import statusPkg::*;

  logic request;  // Master presents a cycle
  logic ackWrite; // Acknowledged write beat

  assign request  = wbCyc & wbStb;
  assign ackWrite = wbAck & wbWe;

  // One wait state, then a single ack cycle followed by a low cycle
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      wbAck <= 1'b0;
    end else begin
      wbAck <= request & ~wbAck;
    end
  end

  // Strobes land on the edge that ends the ack cycle
  assign hostCpsrWrite = ackWrite & (wbAdr == AdrCpsr);
  assign hostSpsrWrite = ackWrite & (wbAdr == AdrSpsr);
  assign hostData      = statusWord_t'(wbDatW[11:0]); // Low 12 bits carry the word

  // Read mux, zero-extended
  always_comb begin
    case (wbAdr)
      AdrCpsr:    wbDatR = {20'h0_0000, status};
      AdrSpsr:    wbDatR = {20'h0_0000, spsr};
      AdrPending: wbDatR = {28'h000_0000, pending};
      default:    wbDatR = 32'h0000_0000; // Unmapped
    endcase
  end

endmodule

// ==== design/exceptionUnit.sv ====
module exceptionUnit #(
  parameter logic [31:0] VectorBase = 32'h0000_0000 // 32'hFFFF_0000 for high vectors
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   dataAbortReq,
  input  logic                   prefetchAbortReq,
  input  logic                   undefReq,
  input  logic                   swiReq,
  input  logic                   irqLine,
  input  logic                   fiqLine,
  input  logic                   excReturn,
  input  logic                   flagsWrite,
  input  logic [3:0]             flagsNext,
  input  logic                   thumbNext,
  input  logic                   wbCyc,
  input  logic                   wbStb,
  input  logic                   wbWe,
  input  logic [1:0]             wbAdr,
  input  logic [31:0]            wbDatW,
  output logic [31:0]            wbDatR,
  output logic                   wbAck,
  output statusPkg::statusWord_t status,
  output logic                   excTaken,
  output statusPkg::excCode_t    excCode,
  output logic [31:0]            excVector
);

  import statusPkg::*;

  statusWord_t spsr;          // Saved word of current mode
  statusWord_t hostData;      // Host write data
  logic        hostCpsrWrite;
  logic        hostSpsrWrite;
  logic [3:0]  pending;       // Latched synchronous requests

  exceptionArbiter #(
    .VectorBase(VectorBase)
  ) exceptionArbiter_inst (
    .clk, .reset,
    .dataAbortReq, .prefetchAbortReq, .undefReq, .swiReq,
    .irqLine, .fiqLine,
    .status,
    .excTaken, .excCode, .excVector,
    .pending
  );

  statusRegister statusRegister_inst (
    .clk, .reset,
    .excTaken, .excCode,
    .excReturn, .flagsWrite, .flagsNext, .thumbNext,
    .hostCpsrWrite, .hostSpsrWrite, .hostData,
    .status, .spsr
  );

  statusBusSlave statusBusSlave_inst (
    .clk, .reset,
    .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck,
    .status, .spsr, .pending,
    .hostCpsrWrite, .hostSpsrWrite, .hostData
  );

endmodule

// ==== test/exceptionUnitSva.sv ====
module exceptionUnitSva (
  input logic                   clk,
  input logic                   reset,
  input logic                   wbCyc,
  input logic                   wbStb,
  input logic                   wbAck,
  input logic                   excTaken,
  input statusPkg::statusWord_t status
);
  timeunit 1ns;
  timeprecision 100ps;

  import statusPkg::*;

  // Ack is a single cycle
  ackSingle: assert property (@(posedge clk) disable iff (reset) wbAck |=> !wbAck)
    else $error("wbAck stayed high for a second cycle");

  // Ack only answers a request seen one cycle earlier
  ackAfterRequest: assert property (@(posedge clk) disable iff (reset)
    wbAck |-> $past(wbCyc && wbStb))
    else $error("wbAck without wbCyc and wbStb in the previous cycle");

  // Entry masks irq, lands in a privileged mode
  entryPrivileged: assert property (@(posedge clk) disable iff (reset)
    excTaken |=> status.irqMask && (status.mode != ModeUser))
    else $error("exception entry left I clear or mode user");

  // Both masks set right out of reset
  resetMasks: assert property (@(posedge clk)
    $fell(reset) |-> status.irqMask && status.fiqMask)
    else $error("I or F clear in the first cycle after reset");

endmodule

bind exceptionUnit exceptionUnitSva exceptionUnitSva_inst (
  .clk(clk),
  .reset(reset),
  .wbCyc(wbCyc),
  .wbStb(wbStb),
  .wbAck(wbAck),
  .excTaken(excTaken),
  .status(status)
);

// ==== test/exceptionUnitTb.sv ====
module exceptionUnitTb;
  timeunit 1ns;
  timeprecision 100ps;

  import statusPkg::*;

  localparam logic [31:0] VectorBase    = 32'hFFFF_0000; // High vectors
  localparam int          ClkPeriod     = 4;
  localparam int          NumTests      = 6;
  localparam int          CyclesPerTest = 200;
  localparam int          AckTimeout    = 16;            // Cycles to wait for wbAck
  localparam int          TakeTimeout   = 20;            // Cycles to wait for excTaken

  logic        clk;
  logic        reset;
  logic        dataAbortReq;
  logic        prefetchAbortReq;
  logic        undefReq;
  logic        swiReq;
  logic        irqLine;
  logic        fiqLine;
  logic        excReturn;
  logic        flagsWrite;
  logic [3:0]  flagsNext;
  logic        thumbNext;
  logic        wbCyc;
  logic        wbStb;
  logic        wbWe;
  logic [1:0]  wbAdr;
  logic [31:0] wbDatW;
  logic [31:0] wbDatR;
  logic        wbAck;
  statusWord_t status;
  logic        excTaken;
  excCode_t    excCode;
  logic [31:0] excVector;

  string       curTest;
  int          testErrors;
  int          errorCount;
  int          testsRun;
  int          testsFailed;
  bit          verdictDone;  // Set once a closing verdict is printed

  exceptionUnit #(
    .VectorBase(VectorBase)
  ) exceptionUnit_inst (.*);

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Status word built from its fields
  function automatic logic [11:0] makeWord(logic [3:0] flags, logic i, logic f, logic t,
                                           logic [4:0] mode);
    return {flags, i, f, t, mode};
  endfunction

  task automatic checkValue(string what, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected) else begin
      $display("mismatch %s %s: expected %h actual %h", curTest, what, expected, actual);
      testErrors++;
    end
  endtask

  task automatic reportFailure(string msg);
    $display("%s: %s", curTest, msg);
    testErrors++;
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1; // Drive point
  endtask

  // Classic Wishbone access entered and left at the drive point
  task automatic busAccess(input logic we, input logic [1:0] adr, input logic [31:0] data,
                           output logic [31:0] rdata);
    int waitCycles;
    int acks;
    waitCycles = 0;
    acks = 0;
    rdata = '0;
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = we;
    wbAdr = adr;
    wbDatW = data;
    @(negedge clk);
    while (!wbAck && waitCycles < AckTimeout) begin
      nextCycle();
      @(negedge clk);
      waitCycles++;
    end
    if (wbAck) begin
      acks++;
      rdata = wbDatR;                  // Valid during ack
      checkValue("wbAck wait", 32'd1, waitCycles);
    end else begin
      reportFailure("wbAck never came while the bus cycle was held");
    end
    nextCycle();                       // Write lands on this edge
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    @(negedge clk);
    if (wbAck) begin
      acks++;                          // Ack must not linger
    end
    checkValue("wbAck cycles", 32'd1, acks);
    nextCycle();
  endtask

  task automatic busWrite(logic [1:0] adr, logic [31:0] data);
    logic [31:0] unused;
    busAccess(1'b1, adr, data, unused);
  endtask

  task automatic busRead(logic [1:0] adr, output logic [31:0] rdata);
    busAccess(1'b0, adr, 32'h0, rdata);
  endtask

  // One-cycle pulse in dataAbort prefetchAbort undef swi order
  task automatic pulseRequests(logic [3:0] reqs);
    {dataAbortReq, prefetchAbortReq, undefReq, swiReq} = reqs;
    nextCycle();
    {dataAbortReq, prefetchAbortReq, undefReq, swiReq} = 4'b0000;
  endtask

  task automatic waitForTaken(excCode_t expected);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!excTaken && waited < TakeTimeout) begin
      nextCycle();
      @(negedge clk);
      waited++;
    end
    if (excTaken) begin
      checkValue("excCode", 32'(expected), 32'(excCode));
    end else begin
      reportFailure("no exception was taken after the request");
    end
    nextCycle();                       // Entry edge
  endtask

  task automatic startTest(string name);
    curTest = name;
    testErrors = 0;
  endtask

  task automatic endTest();
    testsRun++;
    errorCount += testErrors;
    if (testErrors != 0) begin
      testsFailed++;
      $display("test %s failed with %0d errors", curTest, testErrors);
    end else begin
      $display("test %s passed", curTest);
    end
  endtask

  task automatic priorityTest();
    excCode_t    codes [5]   = '{ExcDataAbort, ExcFiq, ExcPrefetchAbort, ExcUndef, ExcSwi};
    logic [31:0] offsets [5] = '{32'h10, 32'h1C, 32'h0C, 32'h04, 32'h08};
    busWrite(AdrCpsr, 32'h013);        // svc with I and F clear
    pulseRequests(4'b1111);
    irqLine = 1'b1;                    // Lines rise once the pulses are pending
    fiqLine = 1'b1;
    for (int k = 0; k < 5; k++) begin
      @(negedge clk);
      checkValue("excTaken", 32'd1, 32'(excTaken));
      checkValue("excCode", 32'(codes[k]), 32'(excCode));
      checkValue("excVector", VectorBase + offsets[k], excVector);
      nextCycle();
    end
    @(negedge clk);
    checkValue("excTaken after sequence", 32'd0, 32'(excTaken)); // irq masked for good
    checkValue("status after swi", 32'h0D3, 32'(status));
    nextCycle();
    irqLine = 1'b0;
    fiqLine = 1'b0;
  endtask

  initial begin
    int unsigned seedValue;
    int unsigned rnd;
    logic [31:0] rdata;
    seedValue = $urandom(32'h527b);
    reset = 1'b1;
    {dataAbortReq, prefetchAbortReq, undefReq, swiReq} = 4'b0000;
    irqLine = 1'b0;
    fiqLine = 1'b0;
    excReturn = 1'b0;
    flagsWrite = 1'b0;
    flagsNext = 4'h0;
    thumbNext = 1'b0;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = 2'd0;
    wbDatW = 32'h0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    startTest("reset");
    @(negedge clk);
    checkValue("status", 32'h0D3, 32'(status));
    checkValue("status vs ResetStatus", 32'(ResetStatus), 32'(status));
    checkValue("excTaken", 32'd0, 32'(excTaken));
    checkValue("wbAck", 32'd0, 32'(wbAck));
    nextCycle();
    busRead(AdrPending, rdata);
    checkValue("pending", 32'h0, rdata);
    endTest();

    startTest("priority");
    priorityTest();
    endTest();

    startTest("entryReturn");
    busWrite(AdrCpsr, 32'h0AF3);       // Flags A with I F T set in svc
    pulseRequests(4'b0010);            // undef
    waitForTaken(ExcUndef);
    @(negedge clk);
    checkValue("status in undef", 32'(makeWord(4'hA, 1, 1, 0, 5'b11011)), 32'(status));
    nextCycle();
    busRead(AdrSpsr, rdata);
    checkValue("spsr", 32'h0AF3, rdata);
    excReturn = 1'b1;
    nextCycle();
    excReturn = 1'b0;
    @(negedge clk);
    checkValue("status after return", 32'h0AF3, 32'(status));
    nextCycle();
    endTest();

    startTest("irqMask");
    irqLine = 1'b1;
    repeat (5) begin
      @(negedge clk);
      checkValue("excTaken while masked", 32'd0, 32'(excTaken));
      nextCycle();
    end
    busWrite(AdrCpsr, 32'h0A73);       // Clears I so irq is taken right after
    @(negedge clk);
    checkValue("status in irq", 32'(makeWord(4'hA, 1, 1, 0, 5'b10010)), 32'(status));
    checkValue("excTaken after entry", 32'd0, 32'(excTaken));
    nextCycle();
    irqLine = 1'b0;
    busRead(AdrSpsr, rdata);
    checkValue("irq spsr", 32'h0A73, rdata);
    endTest();

    startTest("busUser");
    busWrite(AdrCpsr, 32'h0D0);        // Drop to user with masks kept
    busRead(AdrCpsr, rdata);
    checkValue("cpsr in user", 32'h0D0, rdata);
    busWrite(AdrCpsr, 32'h5F3);        // Only flags may change
    busRead(AdrCpsr, rdata);
    checkValue("cpsr after user write", 32'h5D0, rdata);
    busWrite(AdrSpsr, 32'h0FF);        // No bank in user
    busRead(AdrSpsr, rdata);
    checkValue("spsr in user", 32'h0, rdata);
    busRead(2'd3, rdata);
    checkValue("unmapped", 32'h0, rdata);
    busRead(AdrPending, rdata);
    checkValue("pending", 32'h0, rdata);
    endTest();

    startTest("flagsWrite");
    repeat (4) begin
      rnd = $urandom;
      flagsNext = rnd[3:0];
      thumbNext = rnd[4];
      flagsWrite = 1'b1;
      nextCycle();
      flagsWrite = 1'b0;
      @(negedge clk);
      checkValue("status", 32'(makeWord(rnd[3:0], 1, 1, rnd[4], 5'b10000)), 32'(status));
      nextCycle();
    end
    endTest();

    $display("%0d tests run, %0d failed, %0d check errors", testsRun, testsFailed, errorCount);
    verdictDone = 1'b1;
    if (testsFailed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog sized from the test budget
  initial begin
    #(NumTests * CyclesPerTest * ClkPeriod);
    $display("watchdog expired after %0d ns, tests did not finish",
             NumTests * CyclesPerTest * ClkPeriod);
    verdictDone = 1'b1;
    $display("TB FAILED");
    $finish;
  end

  // Run stopped early by a bound assertion
  final begin
    if (!verdictDone) begin
      $display("TB FAILED");
    end
  end

endmodule

// ==== exceptionUnit.f ====
common/statusPkg.sv
statusReg/statusRegister.sv
statusReg/exceptionArbiter.sv
design/statusBusSlave.sv
design/exceptionUnit.sv
test/exceptionUnitSva.sv
test/exceptionUnitTb.sv

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
  --top-module exceptionUnitTb \
  -f exceptionUnit.f \
  -o exceptionUnitSim

simStatus=0
./obj_dir/exceptionUnitSim > sim.log 2>&1 || simStatus=$?
cat sim.log

if grep -qx "TB PASSED" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, exit status $simStatus"
exit 1
